/* project.f */
+incdir+include
rtl/window_pkg.sv
rtl/window_regs.sv
rtl/window_coeff_ram.sv
rtl/window_mult.sv
rtl/window_out_buf.sv
rtl/window_top.sv
dv/window_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module window_tb -f project.f

out="$(./obj_dir/Vwindow_tb)"
printf '%s\n' "$out"

# Status of the run is the status of this search
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"

/* dv/window_tb.sv */
`timescale 1ns/10ps

`include "window_defs.svh"

module window_tb;

  import window_pkg::*;

  localparam int          TIMEOUT  = 2000;
  localparam int          CRED_MAX = (1 << `WIN_CREDIT_W) - 1;
  localparam logic [31:0] SEED     = 32'h8551539e;

  logic                   clk;
  logic                   rst;
  logic                   req_wr;
  logic                   req_rd;
  logic [`WIN_ADDR_W-1:0] req_addr;
  logic [`WIN_DATA_W-1:0] req_data;
  logic                   resp_ack;
  logic [`WIN_DATA_W-1:0] resp_data;
  logic                   in_valid;
  sample_t                in_data;
  logic                   in_last;
  logic                   in_credit;
  logic                   out_valid;
  sample_t                out_data;
  logic                   out_last;
  logic                   out_credit;

  // Reference model of the window
  coeff_t                ref_coeff [`WIN_MAX_SIZE];
  logic [`WIN_IDX_W-1:0] ref_ptr;
  logic [`WIN_IDX_W-1:0] ref_k;
  int                    ref_size;
  sample_t               exp_data [$];
  logic                  exp_last [$];

  // Credit bookkeeping, both sides
  int          sent;
  int          returned;
  int          dn_model;
  int          credit_mode;
  logic [31:0] stim_state;
  logic [31:0] cred_state;

  string cur_test;
  int    errors;
  int    err_start;
  int    pass_n;
  int    fail_n;
  bit    timed_out;

  window_top i_window_top (
    .clk        (clk),
    .rst        (rst),
    .req_wr     (req_wr),
    .req_rd     (req_rd),
    .req_addr   (req_addr),
    .req_data   (req_data),
    .resp_ack   (resp_ack),
    .resp_data  (resp_data),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_last    (in_last),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_last   (out_last),
    .out_credit (out_credit)
  );

  always #4 clk = ~clk;

  // --------------------------------------------------
  // Random source and arithmetic model
  // --------------------------------------------------
  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    stim_state = lcg(stim_state);
    return stim_state;
  endfunction

  // Q1.15 product, round half up, clip
  function automatic logic signed [15:0] apply_coeff(input logic signed [15:0] x,
                                                     input coeff_t c);
    longint p;
    p = (longint'(x) * longint'(c) + 64'sd16384) >>> 15;
    if (p > 64'sd32767) return 16'sh7FFF;
    if (p < -64'sd32768) return 16'sh8000;
    return p[15:0];
  endfunction

  function automatic logic signed [15:0] extreme_val(input logic [1:0] sel);
    case (sel)
      2'd0:    return 16'sh8000;
      2'd1:    return 16'sh7FFF;
      2'd2:    return 16'sh8001;
      default: return 16'sh0001;
    endcase
  endfunction

  // Upstream credits still held by the sender
  function automatic int avail();
    return `WIN_BUF_DEPTH + returned - sent;
  endfunction

  // --------------------------------------------------
  // Compare tasks and test bookkeeping
  // --------------------------------------------------
  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input logic [`WIN_DATA_W-1:0] got,
                           input logic [`WIN_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout in test %s while waiting for %s", cur_test, what);
    timed_out = 1'b1;
    errors++;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    err_start = errors;
  endtask

  task automatic finish_test();
    if (errors == err_start) begin
      pass_n++;
      $display("Test %s: pass", cur_test);
    end else begin
      fail_n++;
      $display("Test %s: fail with %0d errors", cur_test, errors - err_start);
    end
  endtask

  // --------------------------------------------------
  // Register port
  // --------------------------------------------------
  // Called and returns 1 ns after a rising edge
  task automatic reg_access(input logic wr, input logic [`WIN_ADDR_W-1:0] addr,
                            input logic [`WIN_DATA_W-1:0] data,
                            output logic [`WIN_DATA_W-1:0] rdata);
    int n;
    req_wr   = wr;
    req_rd   = !wr;
    req_addr = addr;
    req_data = data;
    @(posedge clk);
    #1;
    req_wr = 1'b0;
    req_rd = 1'b0;
    n = 1;
    while (!resp_ack && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    rdata = resp_data;
    if (!resp_ack) begin
      report_timeout("resp_ack");
    end else if (n != 1) begin
      $display("Register ack came after %0d cycles in test %s", n, cur_test);
      errors++;
    end
  endtask

  task automatic write_size(input int v);
    logic [`WIN_DATA_W-1:0] rd;
    reg_access(1'b1, `WIN_REG_SIZE, 32'(v), rd);
    ref_size = v;
  endtask

  task automatic load_coeff(input coeff_t c, input bit last);
    logic [`WIN_DATA_W-1:0] rd;
    reg_access(1'b1, last ? `WIN_REG_LOAD_LAST : `WIN_REG_LOAD, {16'h0000, c}, rd);
    ref_coeff[ref_ptr] = c;
    ref_ptr = last ? '0 : ref_ptr + `WIN_IDX_W'(1);
  endtask

  // --------------------------------------------------
  // Stream side
  // --------------------------------------------------
  task automatic wait_credit();
    int n;
    n = 0;
    while (avail() == 0 && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (avail() == 0) report_timeout("an input credit");
  endtask

  task automatic send_samples(input int n, input bit extreme, input bit rand_last);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    sample_t     s;
    sample_t     e;
    logic        l;
    for (int i = 0; i < n && !timed_out; i++) begin
      wait_credit();
      if (timed_out) break;
      r1 = rand32();
      r2 = rand32();
      r3 = rand32();
      if (extreme) begin
        s.i = extreme_val(r1[31:30]);
        s.q = extreme_val(r2[31:30]);
      end else begin
        s.i = r1[31:16];
        s.q = r2[31:16];
      end
      // Final sample always closes the frame
      l = (i == n - 1) || (rand_last && r3[31:29] == 3'd0);
      e.i = apply_coeff(s.i, ref_coeff[ref_k]);
      e.q = apply_coeff(s.q, ref_coeff[ref_k]);
      exp_data.push_back(e);
      exp_last.push_back(l);
      if (l || int'(ref_k) == ref_size - 1) ref_k = '0;
      else ref_k = ref_k + `WIN_IDX_W'(1);
      in_valid = 1'b1;
      in_data  = s;
      in_last  = l;
      sent++;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      in_last  = 1'b0;
    end
  endtask

  // All outputs seen and every input credit back
  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_data.size() != 0 || avail() != `WIN_BUF_DEPTH) && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_data.size() != 0 || avail() != `WIN_BUF_DEPTH) begin
      report_timeout("the output to drain");
    end else begin
      repeat (8) @(posedge clk);
      #1;
      if (avail() != `WIN_BUF_DEPTH) begin
        $display("Upstream holds %0d credits after drain in test %s, expected %0d",
                 avail(), cur_test, `WIN_BUF_DEPTH);
        errors++;
      end
    end
  endtask

  // Stall with output credits held back, then trickle them
  task automatic stall_check();
    int n;
    int r0;
    n = 0;
    while (!(avail() == 0 && dn_model == 0) && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (avail() != 0 || dn_model != 0) begin
      report_timeout("upstream to run out of credits");
    end else begin
      r0 = returned;
      repeat (30) @(posedge clk);
      #1;
      if (returned != r0) begin
        $display("Input credit returned in test %s while output credits were held", cur_test);
        errors++;
      end
      if (exp_data.size() != `WIN_BUF_DEPTH) begin
        $display("Buffer holds %0d samples in test %s, expected %0d",
                 exp_data.size(), cur_test, `WIN_BUF_DEPTH);
        errors++;
      end
    end
    credit_mode = 3;
  endtask

  // --------------------------------------------------
  // Downstream credit source
  // --------------------------------------------------
  initial begin
    out_credit = 1'b0;
    cred_state = ~SEED;
    forever begin
      @(posedge clk);
      #1;
      cred_state = lcg(cred_state);
      case (credit_mode)
        0:       out_credit = 1'b0;
        1:       out_credit = 1'b1;
        2:       out_credit = cred_state[31];
        default: out_credit = (cred_state[31:29] == 3'd0);
      endcase
    end
  end

  // Output monitor, mid-cycle where outputs are settled
  initial begin
    returned = 0;
    dn_model = 0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (in_credit) returned++;
        if (out_valid) begin
          if (dn_model == 0) begin
            $display("out_valid without a downstream credit in test %s", cur_test);
            errors++;
          end
          if (exp_data.size() == 0) begin
            $display("Unexpected output with no expected sample in test %s", cur_test);
            errors++;
          end else begin
            check_sample("out_data", out_data, exp_data.pop_front());
            check_last("out_last", out_last, exp_last.pop_front());
          end
        end
        // Grant and send together cancel out
        if (out_credit && !out_valid && dn_model != CRED_MAX) dn_model++;
        else if (out_valid && !out_credit) dn_model--;
      end
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [`WIN_DATA_W-1:0] rd;
    logic [31:0]            r;
    int                     v;
    clk         = 1'b0;
    rst         = 1'b1;
    req_wr      = 1'b0;
    req_rd      = 1'b0;
    req_addr    = '0;
    req_data    = '0;
    in_valid    = 1'b0;
    in_data     = '0;
    in_last     = 1'b0;
    stim_state  = SEED;
    credit_mode = 0;
    sent        = 0;
    errors      = 0;
    pass_n      = 0;
    fail_n      = 0;
    timed_out   = 1'b0;
    ref_ptr     = '0;
    ref_k       = '0;
    ref_size    = `WIN_MAX_SIZE;
    for (int j = 0; j < `WIN_MAX_SIZE; j++) ref_coeff[j] = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    start_test("registers");
    reg_access(1'b0, `WIN_REG_MAX_SIZE, '0, rd);
    check_reg("resp_data", rd, 32'(`WIN_MAX_SIZE));
    r = rand32();
    v = int'(r[31:24]) + 1;
    write_size(v);
    reg_access(1'b0, `WIN_REG_SIZE, '0, rd);
    check_reg("resp_data", rd, 32'(v));
    reg_access(1'b0, 20'h00010, '0, rd);
    check_reg("resp_data", rd, '0);
    reg_access(1'b0, 20'hFFFFC, '0, rd);
    check_reg("resp_data", rd, '0);
    write_size(`WIN_MAX_SIZE);
    finish_test();

    if (!timed_out) begin
      start_test("full_window");
      for (int j = 0; j < `WIN_MAX_SIZE; j++) begin
        r = rand32();
        load_coeff(r[31:16], j == `WIN_MAX_SIZE - 1);
      end
      credit_mode = 1;
      send_samples(600, 1'b0, 1'b0);
      wait_drain();
      finish_test();
    end

    if (!timed_out) begin
      start_test("short_window");
      write_size(5);
      credit_mode = 2;
      send_samples(200, 1'b0, 1'b1);
      wait_drain();
      finish_test();
    end

    if (!timed_out) begin
      start_test("saturation");
      write_size(2);
      load_coeff(16'sh7FFF, 1'b0);
      load_coeff(16'sh8000, 1'b1);
      credit_mode = 1;
      send_samples(64, 1'b1, 1'b0);
      wait_drain();
      finish_test();
    end

    if (!timed_out) begin
      start_test("back_pressure");
      write_size(`WIN_MAX_SIZE);
      credit_mode = 0;
      fork
        send_samples(40, 1'b0, 1'b0);
        stall_check();
      join
      wait_drain();
      finish_test();
    end

    $display("Tests passed: %0d, failed: %0d", pass_n, fail_n);
    if (fail_n == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* rtl/window_top.sv */
`timescale 1ns/10ps

`include "window_defs.svh"

module window_top (
  input  logic                   clk,
  input  logic                   rst,
  // Register port
  input  logic                   req_wr,
  input  logic                   req_rd,
  input  logic [`WIN_ADDR_W-1:0] req_addr,
  input  logic [`WIN_DATA_W-1:0] req_data,
  output logic                   resp_ack,
  output logic [`WIN_DATA_W-1:0] resp_data,
  // Input stream
  input  logic                   in_valid,
  input  window_pkg::sample_t    in_data,
  input  logic                   in_last,
  output logic                   in_credit,
  // Output stream
  output logic                   out_valid,
  output window_pkg::sample_t    out_data,
  output logic                   out_last,
  input  logic                   out_credit
);

  import window_pkg::*;

  // Control to the coefficient store
  logic [`WIN_SIZE_W-1:0] window_size;
  logic                   coeff_wr_en;
  coeff_t                 coeff_wr_data;
  logic                   coeff_wr_last;
  // Datapath links
  coeff_t                 coeff_rd;
  logic                   mult_valid;
  sample_t                mult_data;
  logic                   mult_last;

  // ------------------------------------------------
  // Control
  // ------------------------------------------------
  window_regs i_window_regs (
    .clk           (clk),
    .rst           (rst),
    .req_wr        (req_wr),
    .req_rd        (req_rd),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .resp_ack      (resp_ack),
    .resp_data     (resp_data),
    .window_size   (window_size),
    .coeff_wr_en   (coeff_wr_en),
    .coeff_wr_data (coeff_wr_data),
    .coeff_wr_last (coeff_wr_last)
  );

  // ------------------------------------------------
  // Datapath
  // ------------------------------------------------
  window_coeff_ram i_window_coeff_ram (
    .clk           (clk),
    .rst           (rst),
    .window_size   (window_size),
    .coeff_wr_en   (coeff_wr_en),
    .coeff_wr_data (coeff_wr_data),
    .coeff_wr_last (coeff_wr_last),
    .in_valid      (in_valid),
    .in_last       (in_last),
    .coeff_rd      (coeff_rd)
  );

  // Sample meets its coefficient in stage 1
  window_mult i_window_mult (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_last    (in_last),
    .coeff_rd   (coeff_rd),
    .mult_valid (mult_valid),
    .mult_data  (mult_data),
    .mult_last  (mult_last)
  );

  window_out_buf i_window_out_buf (
    .clk        (clk),
    .rst        (rst),
    .mult_valid (mult_valid),
    .mult_data  (mult_data),
    .mult_last  (mult_last),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_last   (out_last),
    .in_credit  (in_credit)
  );

endmodule

/* rtl/window_out_buf.sv */
`timescale 1ns/10ps

`include "window_defs.svh"

module window_out_buf (
  input  logic                clk,
  input  logic                rst,
  // From the multiplier
  input  logic                mult_valid,
  input  window_pkg::sample_t mult_data,
  input  logic                mult_last,
  // Downstream side
  input  logic                out_credit,
  output logic                out_valid,
  output window_pkg::sample_t out_data,
  output logic                out_last,
  // Upstream credit return
  output logic                in_credit
);

  import window_pkg::*;

  localparam logic [`WIN_BUF_PTR_W-1:0] PTR_ONE  = 1;
  localparam logic [`WIN_BUF_PTR_W:0]   CNT_ONE  = 1;
  localparam logic [`WIN_CREDIT_W-1:0]  CRED_ONE = 1;

  // FIFO storage
  sample_t data_mem [`WIN_BUF_DEPTH];
  logic    last_mem [`WIN_BUF_DEPTH];

  logic [`WIN_BUF_PTR_W-1:0] wr_ptr;
  logic [`WIN_BUF_PTR_W-1:0] rd_ptr;
  logic [`WIN_BUF_PTR_W:0]   fill;
  logic [`WIN_CREDIT_W-1:0]  credits;
  logic                      pop;

  // Send whenever data and a credit are both present
  assign pop       = (fill != '0) && (credits != '0);
  assign out_valid = pop;
  assign out_data  = data_mem[rd_ptr];
  assign out_last  = last_mem[rd_ptr];

  // Upstream guarantees no write into a full FIFO
  always_ff @(posedge clk) begin
    if (mult_valid) begin
      data_mem[wr_ptr] <= mult_data;
      last_mem[wr_ptr] <= mult_last;
    end
  end

  // ------------------------------------------------
  // Pointers, fill level and credits
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      credits   <= '0;
      in_credit <= 1'b0;
    end else begin
      if (mult_valid) begin
        wr_ptr <= wr_ptr + PTR_ONE;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_ONE;
      end
      if (mult_valid && !pop) begin
        fill <= fill + CNT_ONE;
      end else if (pop && !mult_valid) begin
        fill <= fill - CNT_ONE;
      end
      // Grant with send leaves the count alone
      if (out_credit && !pop && credits != '1) begin
        credits <= credits + CRED_ONE;
      end else if (pop && !out_credit) begin
        credits <= credits - CRED_ONE;
      end
      // One returned credit per departed sample
      in_credit <= pop;
    end
  end

endmodule

/* rtl/window_mult.sv */
`timescale 1ns/10ps

module window_mult (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  window_pkg::sample_t in_data,
  input  logic                in_last,
  input  window_pkg::coeff_t  coeff_rd,
  output logic                mult_valid,
  output window_pkg::sample_t mult_data,
  output logic                mult_last
);

  import window_pkg::*;

  // Round half up, drop 15 fraction bits, clip to 16 bits
  function automatic coeff_t round_sat(input logic signed [31:0] prod);
    logic signed [31:0] rounded;
    logic signed [16:0] shifted;
    rounded = prod + 32'sd16384;
    shifted = rounded[31:15];
    case (shifted[16:15])
      2'b01:   round_sat = 16'sh7FFF;
      2'b10:   round_sat = 16'sh8000;
      default: round_sat = shifted[15:0];
    endcase
  endfunction

  // Stage 1 holds the sample while the memory is read
  sample_t            s1_data;
  logic               s1_valid;
  logic               s1_last;
  // Stage 2 holds the raw products
  logic signed [31:0] s2_prod_i;
  logic signed [31:0] s2_prod_q;
  logic               s2_valid;
  logic               s2_last;

  // ------------------------------------------------
  // Valid and last through the stages
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid   <= 1'b0;
      s1_last    <= 1'b0;
      s2_valid   <= 1'b0;
      s2_last    <= 1'b0;
      mult_valid <= 1'b0;
      mult_last  <= 1'b0;
    end else begin
      s1_valid   <= in_valid;
      s1_last    <= in_last;
      s2_valid   <= s1_valid;
      s2_last    <= s1_last;
      mult_valid <= s2_valid;
      mult_last  <= s2_last;
    end
  end

  // ------------------------------------------------
  // Data path
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    s1_data     <= in_data;
    // Full 32-bit signed products
    s2_prod_i   <= s1_data.i * coeff_rd;
    s2_prod_q   <= s1_data.q * coeff_rd;
    mult_data.i <= round_sat(s2_prod_i);
    mult_data.q <= round_sat(s2_prod_q);
  end

endmodule

/* rtl/window_coeff_ram.sv */
`timescale 1ns/10ps

`include "window_defs.svh"

module window_coeff_ram (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`WIN_SIZE_W-1:0] window_size,
  // Coefficient load
  input  logic                   coeff_wr_en,
  input  window_pkg::coeff_t     coeff_wr_data,
  input  logic                   coeff_wr_last,
  // Sample qualifiers
  input  logic                   in_valid,
  input  logic                   in_last,
  output window_pkg::coeff_t     coeff_rd
);

  import window_pkg::*;

  localparam logic [`WIN_IDX_W-1:0]  IDX_ONE  = 1;
  localparam logic [`WIN_SIZE_W-1:0] SIZE_ONE = 1;

  // Coefficient storage
  coeff_t coeff_mem [`WIN_MAX_SIZE];

  logic [`WIN_IDX_W-1:0]  load_ptr;
  logic [`WIN_IDX_W-1:0]  sample_idx;
  logic [`WIN_SIZE_W-1:0] last_pos;
  logic                   idx_wrap;

  // Final position of the current window
  assign last_pos = window_size - SIZE_ONE;
  // Restart on window end or framed last
  assign idx_wrap = in_last || ({1'b0, sample_idx} == last_pos);

  // ------------------------------------------------
  // Memory write and registered read
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (coeff_wr_en) begin
      coeff_mem[load_ptr] <= coeff_wr_data;
    end
    // Ready next cycle, alongside stage 1 of the multiplier
    if (in_valid) begin
      coeff_rd <= coeff_mem[sample_idx];
    end
  end

  // ------------------------------------------------
  // Load pointer and sample position
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      load_ptr   <= '0;
      sample_idx <= '0;
    end else begin
      if (coeff_wr_en) begin
        load_ptr <= coeff_wr_last ? '0 : load_ptr + IDX_ONE;
      end
      if (in_valid) begin
        sample_idx <= idx_wrap ? '0 : sample_idx + IDX_ONE;
      end
    end
  end

endmodule

/* rtl/window_regs.sv */
`timescale 1ns/10ps

`include "window_defs.svh"

module window_regs (
  input  logic                      clk,
  input  logic                      rst,
  // Register port
  input  logic                      req_wr,
  input  logic                      req_rd,
  input  logic [`WIN_ADDR_W-1:0]    req_addr,
  input  logic [`WIN_DATA_W-1:0]    req_data,
  output logic                      resp_ack,
  output logic [`WIN_DATA_W-1:0]    resp_data,
  // Control to the datapath
  output logic [`WIN_SIZE_W-1:0]    window_size,
  output logic                      coeff_wr_en,
  output window_pkg::coeff_t        coeff_wr_data,
  output logic                      coeff_wr_last
);

  import window_pkg::*;

  localparam logic [`WIN_DATA_W-1:0] MAX_SIZE_WORD = `WIN_MAX_SIZE;

  // Write word seen through the union
  reg_word_u wr_word;

  assign wr_word = req_data;

  // ------------------------------------------------
  // Ack, size register and load strobe
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_ack    <= 1'b0;
      window_size <= `WIN_SIZE_W'(`WIN_MAX_SIZE);
      coeff_wr_en <= 1'b0;
    end else begin
      // Any access answered next cycle
      resp_ack    <= req_wr | req_rd;
      coeff_wr_en <= 1'b0;
      if (req_wr) begin
        case (req_addr)
          `WIN_REG_SIZE: begin
            window_size <= wr_word.size_v.size;
          end
          `WIN_REG_LOAD, `WIN_REG_LOAD_LAST: begin
            coeff_wr_en <= 1'b1;
          end
          default: begin
            // Unmapped write ignored
          end
        endcase
      end
    end
  end

  // ------------------------------------------------
  // Coefficient payload and read data
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    // Payload follows the strobe
    coeff_wr_data <= wr_word.coeff_v.coeff;
    coeff_wr_last <= (req_addr == `WIN_REG_LOAD_LAST);

    // Read mux, zero for writes and holes
    resp_data <= '0;
    if (req_rd) begin
      case (req_addr)
        `WIN_REG_SIZE:     resp_data <= `WIN_DATA_W'(window_size);
        `WIN_REG_MAX_SIZE: resp_data <= MAX_SIZE_WORD;
        default:           resp_data <= '0;
      endcase
    end
  end

endmodule

/* rtl/window_pkg.sv */
`include "window_defs.svh"

package window_pkg;

  // Q1.15 window coefficient
  typedef logic signed [`WIN_COMP_W-1:0] coeff_t;

  // Complex sample, I in the upper half
  typedef struct packed {
    logic signed [`WIN_COMP_W-1:0] i;
    logic signed [`WIN_COMP_W-1:0] q;
  } sample_t;

  // Coefficient view of a register word
  typedef struct packed {
    logic [`WIN_DATA_W-`WIN_COMP_W-1:0] pad;
    coeff_t                             coeff;
  } reg_coeff_t;

  // Window size view of a register word
  typedef struct packed {
    logic [`WIN_DATA_W-`WIN_SIZE_W-1:0] pad;
    logic [`WIN_SIZE_W-1:0]             size;
  } reg_size_t;

  // One write word, decoded per target register
  typedef union packed {
    reg_coeff_t coeff_v;
    reg_size_t  size_v;
  } reg_word_u;

endpackage

/* include/window_defs.svh */
`ifndef WINDOW_DEFS_SVH
`define WINDOW_DEFS_SVH

// Register port geometry
`define WIN_ADDR_W        20
`define WIN_DATA_W        32

// Register map
`define WIN_REG_SIZE      20'h00000
`define WIN_REG_MAX_SIZE  20'h00004
`define WIN_REG_LOAD      20'h00008
`define WIN_REG_LOAD_LAST 20'h0000C

// Window geometry
`define WIN_MAX_SIZE      256
`define WIN_SIZE_W        9
`define WIN_IDX_W         8
`define WIN_COMP_W        16

// Output buffer and credits
`define WIN_BUF_DEPTH     8
`define WIN_BUF_PTR_W     3
`define WIN_CREDIT_W      4

`endif
